// ==== rtl/ising_pkg.sv ====
// sizes, register map and address layout shared by the ising core
// fixed at 8 spins, so one J row and the full bias vector each fill one 32-bit word
package ising_pkg;

    localparam int NUM_SPIN        = 8;
    localparam int BIT_J           = 4;    // signed coupling weight
    localparam int BIT_H           = 4;    // signed bias
    localparam int WB_DW           = 32;
    localparam int WB_AW           = 5;    // word address
    localparam int ROW_W           = $clog2(NUM_SPIN);
    localparam int FIELD_W         = 8;    // holds 8 x +-8 plus a bias
    localparam int REG_IDX_W       = 3;
    localparam int SWEEP_W_DEFAULT = 8;

    //////////////////////////////////////////////////
    // register indices
    //////////////////////////////////////////////////
    localparam logic [REG_IDX_W-1:0] REG_CTRL   = 3'd0;   // bit 0 starts a run
    localparam logic [REG_IDX_W-1:0] REG_STATUS = 3'd1;   // bit 0 busy
    localparam logic [REG_IDX_W-1:0] REG_SWEEPS = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_HBIAS  = 3'd3;   // lane i at bits 4i+3..4i
    localparam logic [REG_IDX_W-1:0] REG_SPIN   = 3'd4;

    //////////////////////////////////////////////////
    // wishbone word address
    //////////////////////////////////////////////////
    // top bit picks the region in both views
    // 0 selects registers, 1 the coupling memory
    typedef union packed {
        struct packed {
            logic                       mem_sel;
            logic [WB_AW-REG_IDX_W-2:0] pad;
            logic [REG_IDX_W-1:0]       idx;
        } reg_view;
        struct packed {
            logic                   mem_sel;
            logic [WB_AW-ROW_W-2:0] pad;
            logic [ROW_W-1:0]       row;
        } mem_view;
    } ising_adr_u;

endpackage

// ==== rtl/ising_j_mem.sv ====
// coupling memory with one WB_DW row per spin and a single synchronous read port
// engine reads always win; the host only gets cycles where eng_ren_i is low
`timescale 1ns/1ps

module ising_j_mem import ising_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             eng_ren_i,
    input  logic [ROW_W-1:0] eng_row_i,
    input  logic             host_req_i,
    input  logic             host_we_i,
    input  logic [ROW_W-1:0] host_row_i,
    input  logic [WB_DW-1:0] host_wdata_i,
    output logic [WB_DW-1:0] rdata_o,
    output logic             host_done_o
);

    logic [WB_DW-1:0] mem_q [NUM_SPIN];
    logic [WB_DW-1:0] rdata_q;
    logic [ROW_W-1:0] raddr;
    logic             ren;
    logic             host_gnt;
    logic             done_q;

    // no second grant while the done pulse is out
    assign host_gnt = host_req_i & ~eng_ren_i & ~done_q;

    // request mux
    always_comb begin
        case (eng_ren_i)
            1'b1: begin
                raddr = eng_row_i;
                ren   = 1'b1;
            end
            default: begin
                raddr = host_row_i;
                ren   = host_gnt & ~host_we_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (host_gnt && host_we_i) begin
            mem_q[host_row_i] <= host_wdata_i;
        end
        if (ren) begin
            rdata_q <= mem_q[raddr];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= host_gnt;
        end
    end

    assign rdata_o     = rdata_q;
    assign host_done_o = done_q;

endmodule

// ==== rtl/ising_field_calc.sv ====
// local field of one spin is the sum of J[i][j] * s_j plus h_i with the diagonal included
// spin bit 1 counts as +1 and 0 as -1; result registered one cycle after row_valid_i
`timescale 1ns/1ps

module ising_field_calc import ising_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      row_valid_i,
    input  logic [WB_DW-1:0]          row_i,
    input  logic [NUM_SPIN-1:0]       spins_i,
    input  logic signed [BIT_H-1:0]   bias_i,
    output logic                      field_valid_o,
    output logic signed [FIELD_W-1:0] field_o
);

    logic signed [FIELD_W-1:0] lane_ext [NUM_SPIN];
    logic signed [FIELD_W-1:0] prod     [NUM_SPIN];
    logic signed [FIELD_W-1:0] lvl1     [NUM_SPIN/2];
    logic signed [FIELD_W-1:0] lvl2     [NUM_SPIN/4];
    logic signed [FIELD_W-1:0] bias_ext;
    logic signed [FIELD_W-1:0] sum;
    logic                      valid_q;
    logic signed [FIELD_W-1:0] field_q;

    // sign extend each weight, negate where the spin is -1
    always_comb begin
        for (int j = 0; j < NUM_SPIN; j++) begin
            lane_ext[j] = {{(FIELD_W-BIT_J){row_i[j*BIT_J+BIT_J-1]}}, row_i[j*BIT_J +: BIT_J]};
            prod[j]     = spins_i[j] ? lane_ext[j] : -lane_ext[j];
        end
    end

    // adder tree
    always_comb begin
        for (int k = 0; k < NUM_SPIN/2; k++) begin
            lvl1[k] = prod[2*k] + prod[2*k+1];
        end
        for (int k = 0; k < NUM_SPIN/4; k++) begin
            lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
        end
        bias_ext = {{(FIELD_W-BIT_H){bias_i[BIT_H-1]}}, bias_i};
        sum      = lvl2[0] + lvl2[1] + bias_ext;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= row_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (row_valid_i) begin
            field_q <= sum;
        end
    end

    assign field_valid_o = valid_q;
    assign field_o       = field_q;

endmodule

// ==== rtl/ising_spin_engine.sv ====
// sequential sweep engine with read, data and field cycles per spin and 24 cycles a sweep
// start is taken only when idle with a nonzero sweep count and spin loads only when idle
// bias is used live from hbias_i, so it should not change during a run
`timescale 1ns/1ps

module ising_spin_engine import ising_pkg::*; #(
    parameter int SWEEP_W = SWEEP_W_DEFAULT
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  logic                    load_i,
    input  logic [NUM_SPIN-1:0]     load_spins_i,
    input  logic [SWEEP_W-1:0]      sweeps_i,
    input  logic [WB_DW-1:0]        hbias_i,
    input  logic [WB_DW-1:0]        rdata_i,
    output logic                    busy_o,
    output logic [NUM_SPIN-1:0]     spins_o,
    output logic                    eng_ren_o,
    output logic [ROW_W-1:0]        eng_row_o,
    output logic                    row_valid_o,
    output logic [NUM_SPIN-1:0]     field_spins_o,
    output logic signed [BIT_H-1:0] field_bias_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_FIELD = 2'd3;

    logic [1:0]                state_q;
    logic [ROW_W-1:0]          row_q;
    logic [SWEEP_W-1:0]        sweep_left_q;
    logic [NUM_SPIN-1:0]       spins_q;
    logic                      last_row;
    logic                      field_valid;
    logic signed [FIELD_W-1:0] field;

    assign last_row = (row_q == ROW_W'(NUM_SPIN-1));

    //////////////////////////////////////////////////
    // sweep FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            row_q        <= '0;
            sweep_left_q <= '0;
            spins_q      <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i && sweeps_i != '0) begin
                        state_q      <= ST_READ;
                        row_q        <= '0;
                        sweep_left_q <= sweeps_i;
                    end
                    if (load_i) begin
                        spins_q <= load_spins_i;
                    end
                end
                ST_READ:  state_q <= ST_DATA;   // row address out
                ST_DATA:  state_q <= ST_FIELD;  // row word into the adder tree
                ST_FIELD: begin
                    // zero field keeps the spin
                    if (field_valid && field != '0) begin
                        spins_q[row_q] <= ~field[FIELD_W-1];
                    end
                    row_q <= row_q + 1'b1;
                    if (last_row) begin
                        sweep_left_q <= sweep_left_q - 1'b1;
                        state_q      <= (sweep_left_q == SWEEP_W'(1)) ? ST_IDLE : ST_READ;
                    end else begin
                        state_q <= ST_READ;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o        = (state_q != ST_IDLE);
    assign spins_o       = spins_q;
    assign eng_ren_o     = (state_q == ST_READ);
    assign eng_row_o     = row_q;
    assign row_valid_o   = (state_q == ST_DATA);
    assign field_spins_o = spins_q;
    assign field_bias_o  = hbias_i[row_q*BIT_H +: BIT_H];

    ising_field_calc i_field_calc (
        .clk_i         (clk_i         ),
        .rst_n_i       (rst_n_i       ),
        .row_valid_i   (row_valid_o   ),
        .row_i         (rdata_i       ),
        .spins_i       (field_spins_o ),
        .bias_i        (field_bias_o  ),
        .field_valid_o (field_valid   ),
        .field_o       (field         )
    );

endmodule

// ==== rtl/ising_wb_regs.sv ====
// wishbone classic slave for the ising core registers and coupling memory
// register accesses ack one cycle after stb; memory accesses ack on host_done_i
// byte selects are not decoded so every write takes the full word
`timescale 1ns/1ps

module ising_wb_regs import ising_pkg::*; #(
    parameter int SWEEP_W = SWEEP_W_DEFAULT
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // wishbone slave
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [WB_AW-1:0]          wb_adr_i,
    input  logic [WB_DW-1:0]          wb_dat_i,
    input  logic [WB_DW/8-1:0]        wb_sel_i,   // writes always take the full word
    output logic [WB_DW-1:0]          wb_dat_o,
    output logic                      wb_ack_o,
    // engine side
    input  logic                      busy_i,
    input  logic [NUM_SPIN-1:0]       spins_i,
    output logic                      start_o,
    output logic                      load_o,
    output logic [NUM_SPIN-1:0]       load_spins_o,
    output logic [SWEEP_W-1:0]        sweeps_o,
    output logic [WB_DW-1:0]          hbias_o,
    // coupling memory side
    input  logic                      host_done_i,
    input  logic [WB_DW-1:0]          host_rdata_i,
    output logic                      host_req_o,
    output logic                      host_we_o,
    output logic [ROW_W-1:0]          host_row_o,
    output logic [WB_DW-1:0]          host_wdata_o
);

    ising_adr_u          adr;
    logic                reg_acc;
    logic                mem_acc;
    logic                reg_wr;
    logic                ack_q;
    logic [WB_DW-1:0]    reg_rdata;
    logic [WB_DW-1:0]    rdata_q;
    logic [SWEEP_W-1:0]  sweeps_q;
    logic [WB_DW-1:0]    hbias_q;
    logic                start_q;
    logic                load_q;
    logic [NUM_SPIN-1:0] load_spins_q;
    logic                host_req_q;

    assign adr     = wb_adr_i;
    assign reg_acc = wb_cyc_i & wb_stb_i & ~adr.reg_view.mem_sel;
    assign mem_acc = wb_cyc_i & wb_stb_i & adr.mem_view.mem_sel;
    assign reg_wr  = reg_acc & wb_we_i & ~ack_q;   // first cycle of the access

    //////////////////////////////////////////////////
    // register file and pulses
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            start_q    <= 1'b0;
            load_q     <= 1'b0;
            sweeps_q   <= '0;
            hbias_q    <= '0;
            host_req_q <= 1'b0;
        end else begin
            ack_q   <= reg_acc & ~ack_q;
            start_q <= reg_wr && (adr.reg_view.idx == REG_CTRL) && wb_dat_i[0];
            load_q  <= reg_wr && (adr.reg_view.idx == REG_SPIN);
            if (reg_wr && adr.reg_view.idx == REG_SWEEPS) begin
                sweeps_q <= wb_dat_i[SWEEP_W-1:0];
            end
            if (reg_wr && adr.reg_view.idx == REG_HBIAS) begin
                hbias_q <= wb_dat_i;
            end
            // held until the memory reports completion
            if (host_done_i) begin
                host_req_q <= 1'b0;
            end else if (mem_acc) begin
                host_req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reg_acc && !ack_q) begin
            rdata_q <= reg_rdata;
        end
        if (reg_wr && adr.reg_view.idx == REG_SPIN) begin
            load_spins_q <= wb_dat_i[NUM_SPIN-1:0];
        end
    end

    // ctrl and unmapped indices read zero
    always_comb begin
        reg_rdata = '0;
        case (adr.reg_view.idx)
            REG_STATUS: reg_rdata[0]            = busy_i;
            REG_SWEEPS: reg_rdata[SWEEP_W-1:0]  = sweeps_q;
            REG_HBIAS:  reg_rdata               = hbias_q;
            REG_SPIN:   reg_rdata[NUM_SPIN-1:0] = spins_i;
            default:    reg_rdata               = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // bus outputs
    //////////////////////////////////////////////////
    assign wb_ack_o = ack_q | host_done_i;
    assign wb_dat_o = host_done_i ? host_rdata_i : rdata_q;

    assign start_o      = start_q;
    assign load_o       = load_q;
    assign load_spins_o = load_spins_q;
    assign sweeps_o     = sweeps_q;
    assign hbias_o      = hbias_q;

    assign host_req_o   = host_req_q;
    assign host_we_o    = wb_we_i;   // master holds these until ack
    assign host_row_o   = adr.mem_view.row;
    assign host_wdata_o = wb_dat_i;

endmodule

// ==== rtl/ising_core_top.sv ====
// ising machine core with wishbone registers, coupling memory and sweep engine
// wb_sel_i is not decoded; wishbone err and retry are not provided
`timescale 1ns/1ps

module ising_core_top import ising_pkg::*; #(
    parameter int SWEEP_W = SWEEP_W_DEFAULT
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [WB_AW-1:0]   wb_adr_i,
    input  logic [WB_DW-1:0]   wb_dat_i,
    input  logic [WB_DW/8-1:0] wb_sel_i,
    output logic [WB_DW-1:0]   wb_dat_o,
    output logic               wb_ack_o
);

    logic                busy;
    logic [NUM_SPIN-1:0] spins;
    logic                start;
    logic                load;
    logic [NUM_SPIN-1:0] load_spins;
    logic [SWEEP_W-1:0]  sweeps;
    logic [WB_DW-1:0]    hbias;
    logic                host_req;
    logic                host_we;
    logic [ROW_W-1:0]    host_row;
    logic [WB_DW-1:0]    host_wdata;
    logic                host_done;
    logic [WB_DW-1:0]    j_rdata;
    logic                eng_ren;
    logic [ROW_W-1:0]    eng_row;

    //////////////////////////////////////////////////
    // host registers
    //////////////////////////////////////////////////
    ising_wb_regs #(
        .SWEEP_W (SWEEP_W)
    ) i_wb_regs (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .wb_cyc_i     (wb_cyc_i   ),
        .wb_stb_i     (wb_stb_i   ),
        .wb_we_i      (wb_we_i    ),
        .wb_adr_i     (wb_adr_i   ),
        .wb_dat_i     (wb_dat_i   ),
        .wb_sel_i     (wb_sel_i   ),
        .wb_dat_o     (wb_dat_o   ),
        .wb_ack_o     (wb_ack_o   ),
        .busy_i       (busy       ),
        .spins_i      (spins      ),
        .start_o      (start      ),
        .load_o       (load       ),
        .load_spins_o (load_spins ),
        .sweeps_o     (sweeps     ),
        .hbias_o      (hbias      ),
        .host_done_i  (host_done  ),
        .host_rdata_i (j_rdata    ),
        .host_req_o   (host_req   ),
        .host_we_o    (host_we    ),
        .host_row_o   (host_row   ),
        .host_wdata_o (host_wdata )
    );

    //////////////////////////////////////////////////
    // coupling memory and engine
    //////////////////////////////////////////////////
    ising_j_mem i_j_mem (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .eng_ren_i    (eng_ren    ),
        .eng_row_i    (eng_row    ),
        .host_req_i   (host_req   ),
        .host_we_i    (host_we    ),
        .host_row_i   (host_row   ),
        .host_wdata_i (host_wdata ),
        .rdata_o      (j_rdata    ),
        .host_done_o  (host_done  )
    );

    ising_spin_engine #(
        .SWEEP_W (SWEEP_W)
    ) i_spin_engine (
        .clk_i         (clk_i      ),
        .rst_n_i       (rst_n_i    ),
        .start_i       (start      ),
        .load_i        (load       ),
        .load_spins_i  (load_spins ),
        .sweeps_i      (sweeps     ),
        .hbias_i       (hbias      ),
        .rdata_i       (j_rdata    ),
        .busy_o        (busy       ),
        .spins_o       (spins      ),
        .eng_ren_o     (eng_ren    ),
        .eng_row_o     (eng_row    ),
        .row_valid_o   (           ),
        .field_spins_o (           ),
        .field_bias_o  (           )
    );

endmodule

// ==== sim/ising_core_sva.sv ====
// bus protocol and engine state assertions bound into ising_core_top
// the *_fails counters are read by the testbench top through instance i_sva
`timescale 1ns/1ps

module ising_core_sva import ising_pkg::*; (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             wb_cyc_i,
    input logic             wb_stb_i,
    input logic [WB_AW-1:0] wb_adr_i,
    input logic             wb_ack_i,
    input logic             busy_i
);

    int   ack_orphan_fails = 0;
    int   ack_long_fails   = 0;
    int   reset_busy_fails = 0;
    int   mem_slow_fails   = 0;
    int   mem_wait;
    logic mem_stb;

    assign mem_stb = wb_cyc_i & wb_stb_i & wb_adr_i[WB_AW-1];   // memory region

    // cycles a memory access has waited so far
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wait <= 0;
        end else if (!mem_stb || wb_ack_i) begin
            mem_wait <= 0;
        end else begin
            mem_wait <= mem_wait + 1;
        end
    end

    a_ack_orphan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            ack_orphan_fails++;
            $error("ack without cyc and stb");
        end

    a_ack_long: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            ack_long_fails++;
            $error("ack high for two cycles");
        end

    a_reset_busy: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !busy_i)
        else begin
            reset_busy_fails++;
            $error("busy high right after reset");
        end

    a_mem_slow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_stb |-> (mem_wait < 4))
        else begin
            mem_slow_fails++;
            $error("memory access not acked within four cycles");
        end

endmodule

bind ising_core_top ising_core_sva i_sva (
    .clk_i    (clk_i    ),
    .rst_n_i  (rst_n_i  ),
    .wb_cyc_i (wb_cyc_i ),
    .wb_stb_i (wb_stb_i ),
    .wb_adr_i (wb_adr_i ),
    .wb_ack_i (wb_ack_o ),
    .busy_i   (busy     )
);

// ==== sim/tb_ising_core.sv ====
// testbench for ising_core_top at the default sweep width
// bus protocol checks sit in the bound ising_core_sva instance i_sva
// j_rows mirrors the coupling memory so the reference model sees what was written
`timescale 1ns/1ps

module tb_ising_core import ising_pkg::*; ();

    localparam int SWEEP_W        = SWEEP_W_DEFAULT;
    localparam int SWEEPS_USED    = 1 + 3 + 4;    // tests 3, 4 and 5
    localparam int BUS_ACCESSES   = 69;           // status polls not counted
    localparam int TIMEOUT_CYCLES = 2 * (SWEEPS_USED * 24 + 200 * BUS_ACCESSES);
    localparam logic [WB_DW-1:0] SWEEP_MASK = {{(WB_DW-SWEEP_W){1'b0}}, {SWEEP_W{1'b1}}};

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_AW-1:0]    wb_adr;
    logic [WB_DW-1:0]    wb_dat_w;
    logic [WB_DW/8-1:0]  wb_sel;
    logic [WB_DW-1:0]    wb_dat_r;
    logic                wb_ack;
    logic [15:0]         lfsr_q;
    logic [WB_DW-1:0]    j_rows [NUM_SPIN];
    int                  err_cnt;
    int                  test_cnt;
    int                  cycle_cnt;
    int                  sva_fails;

    ising_core_top #(
        .SWEEP_W (SWEEP_W)
    ) i_dut (
        .clk_i    (clk      ),
        .rst_n_i  (rst_n    ),
        .wb_cyc_i (wb_cyc   ),
        .wb_stb_i (wb_stb   ),
        .wb_we_i  (wb_we    ),
        .wb_adr_i (wb_adr   ),
        .wb_dat_i (wb_dat_w ),
        .wb_sel_i (wb_sel   ),
        .wb_dat_o (wb_dat_r ),
        .wb_ack_o (wb_ack   )
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // random data and reference model
    //////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [WB_DW-1:0] random_word(int nbits);
        logic [WB_DW-1:0] w;
        w = '0;
        for (int b = 0; b < nbits; b++) begin
            w = {w[WB_DW-2:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic int signed_lane(logic [WB_DW-1:0] w, int k);
        logic signed [BIT_J-1:0] v;
        v = w[k*BIT_J +: BIT_J];
        return int'(v);
    endfunction

    // spins updated in order so each new spin is seen by the next row
    function automatic logic [NUM_SPIN-1:0] model_spins(logic [NUM_SPIN-1:0] s_init,
                                                        logic [WB_DW-1:0] hb, int sweeps);
        logic [NUM_SPIN-1:0] s;
        int                  field;
        int                  jw;
        s = s_init;
        for (int n = 0; n < sweeps; n++) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                field = signed_lane(hb, i);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    jw    = signed_lane(j_rows[i], j);
                    field = s[j] ? field + jw : field - jw;
                end
                if (field > 0) begin
                    s[i] = 1'b1;
                end else if (field < 0) begin
                    s[i] = 1'b0;
                end
            end
        end
        return s;
    endfunction

    function automatic logic [WB_AW-1:0] reg_adr(logic [REG_IDX_W-1:0] idx);
        return {2'b00, idx};
    endfunction

    function automatic logic [WB_AW-1:0] row_adr(int row);
        return {2'b10, ROW_W'(row)};
    endfunction

    //////////////////////////////////////////////////
    // wishbone master
    //////////////////////////////////////////////////
    task automatic finish_access(output logic [WB_DW-1:0] dat);
        do begin
            @(negedge clk);
        end while (!wb_ack);
        dat = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
        logic [WB_DW-1:0] unused_dat;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        finish_access(unused_dat);
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        finish_access(dat);
    endtask

    task automatic check_word(input string what, input logic [WB_DW-1:0] expected,
                              input logic [WB_DW-1:0] actual);
        assert (actual === expected) else begin
            $display("error at %0d ns: %s expected %h, actual %h",
                     $time, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic read_check(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] expected,
                              input string what);
        logic [WB_DW-1:0] got;
        wb_read(adr, got);
        check_word(what, expected, got);
    endtask

    task automatic wait_idle();
        logic [WB_DW-1:0] st;
        do begin
            wb_read(reg_adr(REG_STATUS), st);
        end while (st[0]);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    // random rows, bias and start spins, then the sweep count
    task automatic setup_problem(input int sweeps, output logic [WB_DW-1:0] hb,
                                 output logic [NUM_SPIN-1:0] s0);
        logic [WB_DW-1:0] w;
        for (int r = 0; r < NUM_SPIN; r++) begin
            j_rows[r] = random_word(WB_DW);
            wb_write(row_adr(r), j_rows[r]);
        end
        hb = random_word(WB_DW);
        wb_write(reg_adr(REG_HBIAS), hb);
        w  = random_word(NUM_SPIN);
        s0 = w[NUM_SPIN-1:0];
        wb_write(reg_adr(REG_SPIN), WB_DW'(s0));
        wb_write(reg_adr(REG_SWEEPS), WB_DW'(sweeps));
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic regs_readback();
        logic [WB_DW-1:0] w;
        int               errs;
        errs = err_cnt;
        w = random_word(WB_DW);
        wb_write(reg_adr(REG_SWEEPS), w);
        read_check(reg_adr(REG_SWEEPS), w & SWEEP_MASK, "SWEEPS");
        w = random_word(WB_DW);
        wb_write(reg_adr(REG_HBIAS), w);
        read_check(reg_adr(REG_HBIAS), w, "HBIAS");
        w = random_word(WB_DW);
        wb_write(reg_adr(REG_SPIN), w);
        read_check(reg_adr(REG_SPIN), WB_DW'(w[NUM_SPIN-1:0]), "SPIN");
        for (int idx = 5; idx < 8; idx++) begin
            read_check(reg_adr(REG_IDX_W'(idx)), '0, $sformatf("reg[%0d]", idx));
        end
        end_test("register readback", errs);
    endtask

    task automatic j_mem_readback();
        int errs;
        errs = err_cnt;
        for (int r = 0; r < NUM_SPIN; r++) begin
            j_rows[r] = random_word(WB_DW);
            wb_write(row_adr(r), j_rows[r]);
        end
        for (int r = 0; r < NUM_SPIN; r++) begin
            read_check(row_adr(r), j_rows[r], $sformatf("j_row[%0d]", r));
        end
        end_test("coupling memory readback", errs);
    endtask

    task automatic bias_only_sweep();
        logic [WB_DW-1:0]    hb;
        logic [WB_DW-1:0]    w;
        logic [NUM_SPIN-1:0] s0;
        logic [NUM_SPIN-1:0] exp_s;
        int                  errs;
        int                  lane;
        errs = err_cnt;
        for (int r = 0; r < NUM_SPIN; r++) begin
            j_rows[r] = '0;
            wb_write(row_adr(r), '0);
        end
        hb = random_word(WB_DW);
        wb_write(reg_adr(REG_HBIAS), hb);
        w  = random_word(NUM_SPIN);
        s0 = w[NUM_SPIN-1:0];
        wb_write(reg_adr(REG_SPIN), WB_DW'(s0));
        wb_write(reg_adr(REG_SWEEPS), 32'd1);
        wb_write(reg_adr(REG_CTRL), 32'd1);
        wait_idle();
        exp_s = s0;   // zero bias keeps the spin
        for (int i = 0; i < NUM_SPIN; i++) begin
            lane = signed_lane(hb, i);
            if (lane > 0) begin
                exp_s[i] = 1'b1;
            end else if (lane < 0) begin
                exp_s[i] = 1'b0;
            end
        end
        read_check(reg_adr(REG_SPIN), WB_DW'(exp_s), "SPIN");
        end_test("sign of bias, one sweep", errs);
    endtask

    task automatic multi_sweep();
        logic [WB_DW-1:0]    hb;
        logic [NUM_SPIN-1:0] s0;
        int                  errs;
        errs = err_cnt;
        setup_problem(3, hb, s0);
        wb_write(reg_adr(REG_CTRL), 32'd1);
        wait_idle();
        read_check(reg_adr(REG_SPIN), WB_DW'(model_spins(s0, hb, 3)), "SPIN");
        end_test("three sweeps against model", errs);
    endtask

    task automatic access_while_busy();
        logic [WB_DW-1:0]    hb;
        logic [NUM_SPIN-1:0] s0;
        int                  errs;
        errs = err_cnt;
        setup_problem(4, hb, s0);
        wb_write(reg_adr(REG_CTRL), 32'd1);
        read_check(reg_adr(REG_STATUS), 32'd1, "STATUS");
        wb_write(reg_adr(REG_SPIN), WB_DW'(~s0));   // dropped
        wb_write(reg_adr(REG_CTRL), 32'd1);         // ignored
        read_check(row_adr(5), j_rows[5], "j_row[5]");
        read_check(reg_adr(REG_STATUS), 32'd1, "STATUS");
        wait_idle();
        read_check(reg_adr(REG_SPIN), WB_DW'(model_spins(s0, hb, 4)), "SPIN");
        end_test("host access while busy", errs);
    endtask

    //////////////////////////////////////////////////
    // main sequence and timeout
    //////////////////////////////////////////////////
    initial begin
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = '1;
        rst_n     = 1'b0;
        lfsr_q    = 16'd99;
        err_cnt   = 0;
        test_cnt  = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        regs_readback();
        j_mem_readback();
        bias_only_sweep();
        multi_sweep();
        access_while_busy();
        sva_fails = i_dut.i_sva.ack_orphan_fails + i_dut.i_sva.ack_long_fails
                  + i_dut.i_sva.reset_busy_fails + i_dut.i_sva.mem_slow_fails;
        $display("tests %0d, check errors %0d, assertion failures %0d",
                 test_cnt, err_cnt, sva_fails);
        if (err_cnt == 0 && sva_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, tests still running after %0d cycles", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/ising_pkg.sv
rtl/ising_j_mem.sv
rtl/ising_field_calc.sv
rtl/ising_spin_engine.sv
rtl/ising_wb_regs.sv
rtl/ising_core_top.sv
sim/ising_core_sva.sv
sim/tb_ising_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ising core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ising_core -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_ising_core +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
